/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/dcache_pkg.sv
      - design/dcache_way.sv
      - design/dcache_read_sel.sv
      - design/dcache_ctrl.sv
      - design/dcache_mem_port.sv
      - design/dcache_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/dcache_mem_model.sv
      - test/tb_dcache.sv

/* design/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 valid,
    input  logic                                 op,          // 1 store, 0 load
    input  logic                                 signed_ext,
    input  logic [31:0]                          addr,
    input  logic [31:0]                          wdata,
    input  dcache_pkg::access_size_t             size,
    input  logic [`DC_WAYS-1:0]                  way_hit,
    input  logic [`DC_WAYS-1:0]                  way_valid,
    input  logic [`DC_WAYS-1:0]                  way_dirty,
    input  logic [`DC_WAYS-1:0][`DC_TAG_W-1:0]   way_tags,
    input  dcache_pkg::cache_line_t              hit_line,
    input  dcache_pkg::cache_line_t              victim_line,
    input  dcache_pkg::cache_line_t              refill_line,
    input  logic [31:0]                          load_data,
    input  logic                                 mem_done,
    output logic [`DC_INDEX_W-1:0]               index,
    output logic [`DC_TAG_W-1:0]                 lookup_tag,
    output logic [`DC_OFFSET_W-1:0]              offset,
    output dcache_pkg::access_size_t             size_q,
    output logic                                 signed_ext_q,
    output logic [`DC_WAY_W-1:0]                 victim,
    output logic [`DC_WAYS-1:0]                  line_we,
    output logic [`DC_WAYS-1:0]                  fill,
    output dcache_pkg::cache_line_t              wr_line,
    output logic                                 wr_dirty,
    output logic                                 start_wb,
    output logic                                 start_refill,
    output logic [`DC_LINE_ADDR_W-1:0]           mem_line_addr,
    output dcache_pkg::cache_line_t              wb_line,
    output logic                                 data_valid,
    output logic                                 exception,
    output logic [31:0]                          rdata
);

    dcache_pkg::ctrl_state_t          state, state_next;
    logic [31:0]                      addr_q;
    logic [31:0]                      wdata_q;
    logic                             op_q;
    logic                             misaligned;
    logic                             misaligned_q;
    logic [`DC_SETS-1:0][`DC_WAY_W-1:0] rr_ptr;   // round-robin pointer per set
    logic [`DC_WAY_W-1:0]             invalid_way;
    logic                             has_invalid;
    logic [`DC_WAY_W-1:0]             victim_new;
    logic [`DC_WAY_W-1:0]             victim_q;
    logic                             miss_dirty;

    // write the store bytes into a line via the byte view
    function automatic dcache_pkg::cache_line_t merge_store(
        input dcache_pkg::cache_line_t  line,
        input logic [`DC_OFFSET_W-1:0]  off,
        input dcache_pkg::access_size_t sz,
        input logic [31:0]              data
    );
        dcache_pkg::cache_line_t m;
        int k;
        m = line;
        case (sz)
            dcache_pkg::size_byte: m.bytes[off] = data[7:0];
            dcache_pkg::size_half: begin
                m.bytes[{off[`DC_OFFSET_W-1:1], 1'b0}] = data[7:0];
                m.bytes[{off[`DC_OFFSET_W-1:1], 1'b1}] = data[15:8];
            end
            default: begin
                for (k = 0; k < 4; k++) begin
                    m.bytes[{off[`DC_OFFSET_W-1:2], 2'(k)}] = data[8*k +: 8];
                end
            end
        endcase
        return m;
    endfunction

    assign misaligned = (size == dcache_pkg::size_half && addr[0]) ||
                        (size == dcache_pkg::size_word && addr[1:0] != 2'b00);

    assign offset     = addr_q[`DC_OFFSET_W-1:0];
    assign index      = addr_q[`DC_OFFSET_W +: `DC_INDEX_W];
    assign lookup_tag = addr_q[31 -: `DC_TAG_W];

    // lowest invalid way wins, else the set's round-robin way
    always_comb begin
        has_invalid = 1'b0;
        invalid_way = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                has_invalid = 1'b1;
                invalid_way = `DC_WAY_W'(w);
            end
        end
        victim_new = has_invalid ? invalid_way : rr_ptr[index];
    end

    assign miss_dirty = way_valid[victim_new] && way_dirty[victim_new];
    assign victim     = (state == dcache_pkg::lookup) ? victim_new : victim_q;
    assign wb_line    = victim_line;

    // writeback targets the victim's own line, refill the requested one
    assign mem_line_addr = start_wb ? {way_tags[victim_new], index} : {lookup_tag, index};

    always_comb begin
        state_next   = state;
        line_we      = '0;
        fill         = '0;
        wr_line      = hit_line;
        wr_dirty     = 1'b0;
        start_wb     = 1'b0;
        start_refill = 1'b0;
        case (state)
            dcache_pkg::idle: if (valid) state_next = dcache_pkg::lookup;
            dcache_pkg::lookup: begin
                if (misaligned_q) begin
                    state_next = dcache_pkg::respond;   // cache left alone
                end else if (|way_hit) begin
                    if (op_q) begin
                        line_we  = way_hit;
                        wr_line  = merge_store(hit_line, offset, size_q, wdata_q);
                        wr_dirty = 1'b1;
                    end
                    state_next = dcache_pkg::respond;
                end else if (miss_dirty) begin
                    start_wb   = 1'b1;
                    state_next = dcache_pkg::writeback;
                end else begin
                    start_refill = 1'b1;
                    state_next   = dcache_pkg::refill;
                end
            end
            dcache_pkg::writeback: begin
                if (mem_done) begin
                    start_refill = 1'b1;
                    state_next   = dcache_pkg::refill;
                end
            end
            dcache_pkg::refill: begin
                if (mem_done) begin
                    line_we[victim_q] = 1'b1;
                    fill[victim_q]    = 1'b1;
                    wr_line  = op_q ? merge_store(refill_line, offset, size_q, wdata_q)
                                    : refill_line;
                    wr_dirty = op_q;  // clean unless a store went in
                    state_next = dcache_pkg::respond;
                end
            end
            default: state_next = dcache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= dcache_pkg::idle;
            rr_ptr <= '0;
        end else begin
            state <= state_next;
            if (state == dcache_pkg::lookup && !misaligned_q && !(|way_hit) && !has_invalid) begin
                rr_ptr[index] <= rr_ptr[index] + 1'b1;
            end
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::idle && valid) begin
            addr_q       <= addr;
            wdata_q      <= wdata;
            op_q         <= op;
            size_q       <= size;
            signed_ext_q <= signed_ext;
            misaligned_q <= misaligned;
        end
        if (state == dcache_pkg::lookup) begin
            victim_q <= victim_new;
        end
    end

    // way holds the line by respond, so load data comes straight from the selector
    assign data_valid = (state == dcache_pkg::respond);
    assign exception  = (state == dcache_pkg::respond) && misaligned_q;
    assign rdata      = load_data;

endmodule

/* design/dcache_mem_port.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_mem_port (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start_wb,
    input  logic                       start_refill,
    input  logic [`DC_LINE_ADDR_W-1:0] line_addr,
    input  dcache_pkg::cache_line_t    wb_line,
    output logic                       done,
    output dcache_pkg::cache_line_t    refill_line,
    output logic                       mem_req,
    output logic                       mem_we,
    output logic [31:0]                mem_addr,
    output logic [`DC_LINE_W-1:0]      mem_wdata,
    input  logic                       mem_ack,
    input  logic [`DC_LINE_W-1:0]      mem_rdata
);

    logic                       req_q;
    logic                       wait_low;   // req dropped, ack still high
    logic                       we_q;
    logic [`DC_LINE_ADDR_W-1:0] addr_q;
    dcache_pkg::cache_line_t    wdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q    <= 1'b0;
            wait_low <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start_wb || start_refill) begin
                req_q <= 1'b1;
            end else if (req_q && mem_ack) begin
                req_q    <= 1'b0;
                wait_low <= 1'b1;
            end else if (wait_low && !mem_ack) begin
                wait_low <= 1'b0;
                done     <= 1'b1;  // handshake closed
            end
        end
    end

    // address and data held for the whole transaction
    always_ff @(posedge clk) begin
        if (start_wb || start_refill) begin
            we_q    <= start_wb;
            addr_q  <= line_addr;
            wdata_q <= wb_line;
        end
        if (req_q && mem_ack && !we_q) begin
            refill_line <= mem_rdata;
        end
    end

    assign mem_req   = req_q;
    assign mem_we    = we_q;
    assign mem_addr  = {addr_q, {`DC_OFFSET_W{1'b0}}};  // line aligned
    assign mem_wdata = wdata_q;

endmodule

/* design/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// associativity
`define DC_WAYS 4
`define DC_WAY_W 2

// sets per way
`define DC_SETS 16

// line geometry
`define DC_LINE_WORDS 4
`define DC_LINE_W (`DC_LINE_WORDS * 32)
`define DC_LINE_BYTES (`DC_LINE_W / 8)

// address split into tag | index | offset
`define DC_INDEX_W 4
`define DC_OFFSET_W 4
`define DC_TAG_W (32 - `DC_INDEX_W - `DC_OFFSET_W)

// memory side works on line addresses
`define DC_LINE_ADDR_W (`DC_TAG_W + `DC_INDEX_W)

`endif

/* design/dcache_pkg.sv */
`include "dcache_params.svh"

package dcache_pkg;

    // core access width
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    // a cache line seen as words for loads and refill
    // or as bytes when a store is merged in
    typedef union packed {
        logic [`DC_LINE_WORDS-1:0][31:0] words;
        logic [`DC_LINE_BYTES-1:0][7:0]  bytes;
    } cache_line_t;

    // main FSM of the controller
    typedef enum logic [2:0] {
        idle      = 3'd0,
        lookup    = 3'd1,
        writeback = 3'd2,  // dirty victim goes out first
        refill    = 3'd3,
        respond   = 3'd4
    } ctrl_state_t;

endpackage

/* design/dcache_read_sel.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_read_sel (
    input  dcache_pkg::cache_line_t [`DC_WAYS-1:0] way_lines,
    input  logic [`DC_WAYS-1:0]                    way_hit,
    input  logic [`DC_WAY_W-1:0]                   victim,
    input  logic [`DC_OFFSET_W-1:0]                offset,
    input  dcache_pkg::access_size_t               size,
    input  logic                                   signed_ext,
    output dcache_pkg::cache_line_t                hit_line,
    output dcache_pkg::cache_line_t                victim_line,
    output logic [31:0]                            load_data
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;
    logic [31:0] word_val;

    // at most one way hits
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_line = way_lines[w];
            end
        end
    end

    assign victim_line = way_lines[victim];

    assign word_val = hit_line.words[offset[`DC_OFFSET_W-1:2]];
    assign byte_val = hit_line.bytes[offset];
    assign half_val = {hit_line.bytes[{offset[`DC_OFFSET_W-1:1], 1'b1}],
                       hit_line.bytes[{offset[`DC_OFFSET_W-1:1], 1'b0}]};  // little endian

    always_comb begin
        case (size)
            dcache_pkg::size_byte: begin
                load_data = {{24{signed_ext & byte_val[7]}}, byte_val};
            end
            dcache_pkg::size_half: begin
                load_data = {{16{signed_ext & half_val[15]}}, half_val};
            end
            default: load_data = word_val;
        endcase
    end

endmodule

/* design/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  logic                     op,
    input  logic                     signed_ext,
    input  logic [31:0]              addr,
    input  logic [31:0]              wdata,
    input  dcache_pkg::access_size_t size,
    output logic                     data_valid,
    output logic                     exception,
    output logic [31:0]              rdata,
    output logic                     mem_req,
    output logic                     mem_we,
    output logic [31:0]              mem_addr,
    output logic [`DC_LINE_W-1:0]    mem_wdata,
    input  logic                     mem_ack,
    input  logic [`DC_LINE_W-1:0]    mem_rdata
);

    logic [`DC_INDEX_W-1:0]                index;
    logic [`DC_TAG_W-1:0]                  lookup_tag;
    logic [`DC_OFFSET_W-1:0]               offset;
    dcache_pkg::access_size_t              size_q;
    logic                                  signed_ext_q;
    logic [`DC_WAY_W-1:0]                  victim;
    logic [`DC_WAYS-1:0]                   line_we, fill;
    dcache_pkg::cache_line_t               wr_line;
    logic                                  wr_dirty;
    logic [`DC_WAYS-1:0]                   way_hit, way_valid, way_dirty;
    logic [`DC_WAYS-1:0][`DC_TAG_W-1:0]    way_tags;
    dcache_pkg::cache_line_t [`DC_WAYS-1:0] way_lines;
    dcache_pkg::cache_line_t               hit_line, victim_line, refill_line, wb_line;
    logic [31:0]                           load_data;
    logic                                  start_wb, start_refill, mem_done;
    logic [`DC_LINE_ADDR_W-1:0]            mem_line_addr;

    dcache_ctrl ctrl_i (
        .clk, .reset, .valid, .op, .signed_ext, .addr, .wdata, .size,
        .way_hit, .way_valid, .way_dirty, .way_tags,
        .hit_line, .victim_line, .refill_line, .load_data, .mem_done,
        .index, .lookup_tag, .offset, .size_q, .signed_ext_q, .victim,
        .line_we, .fill, .wr_line, .wr_dirty,
        .start_wb, .start_refill, .mem_line_addr, .wb_line,
        .data_valid, .exception, .rdata
    );

    // identical way slices
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dcache_way way_i (
            .clk, .reset, .index, .lookup_tag,
            .line_we    (line_we[w]),
            .fill       (fill[w]),
            .wr_line, .wr_dirty,
            .hit        (way_hit[w]),
            .line_valid (way_valid[w]),
            .line_dirty (way_dirty[w]),
            .line_tag   (way_tags[w]),
            .rd_line    (way_lines[w])
        );
    end

    dcache_read_sel read_sel_i (
        .way_lines, .way_hit, .victim, .offset,
        .size       (size_q),
        .signed_ext (signed_ext_q),
        .hit_line, .victim_line, .load_data
    );

    dcache_mem_port mem_port_i (
        .clk, .reset, .start_wb, .start_refill,
        .line_addr (mem_line_addr),
        .wb_line,
        .done      (mem_done),
        .refill_line,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

endmodule

/* design/dcache_way.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_way (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`DC_INDEX_W-1:0]  index,
    input  logic [`DC_TAG_W-1:0]    lookup_tag,
    input  logic                    line_we,
    input  logic                    fill,
    input  dcache_pkg::cache_line_t wr_line,
    input  logic                    wr_dirty,
    output logic                    hit,
    output logic                    line_valid,
    output logic                    line_dirty,
    output logic [`DC_TAG_W-1:0]    line_tag,
    output dcache_pkg::cache_line_t rd_line
);

    logic [`DC_TAG_W-1:0]    tag_mem  [`DC_SETS];
    dcache_pkg::cache_line_t data_mem [`DC_SETS];
    logic [`DC_SETS-1:0]     valid_bits;
    logic [`DC_SETS-1:0]     dirty_bits;

    // state bits per set
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (line_we) begin
                dirty_bits[index] <= wr_dirty;
            end
            if (fill) begin
                valid_bits[index] <= 1'b1;  // line now owned by this way
            end
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (line_we) begin
            data_mem[index] <= wr_line;
        end
        if (fill) begin
            tag_mem[index] <= lookup_tag;
        end
    end

    // asynchronous read at the current index
    assign line_valid = valid_bits[index];
    assign line_dirty = dirty_bits[index];
    assign line_tag   = tag_mem[index];
    assign rd_line    = data_mem[index];

    assign hit = line_valid && (line_tag == lookup_tag);

endmodule

/* list.f */
+incdir+design
design/dcache_pkg.sv
design/dcache_way.sv
design/dcache_read_sel.sv
design/dcache_ctrl.sv
design/dcache_mem_port.sv
design/dcache_top.sv
test/dcache_mem_model.sv
test/tb_dcache.sv

/* test/dcache_mem_model.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_req,
    input  logic                  mem_we,
    input  logic [31:0]           mem_addr,
    input  logic [`DC_LINE_W-1:0] mem_wdata,
    output logic                  mem_ack,
    output logic [`DC_LINE_W-1:0] mem_rdata
);

    logic [`DC_LINE_W-1:0] lines [256];  // 4 KB backing store
    logic [7:0]            line_idx;
    logic                  busy;
    int                    wait_cnt;
    integer                seed;

    // same preset rule the testbench uses for its shadow copy
    function automatic logic [7:0] preset_byte(input logic [11:0] a);
        logic [7:0] p;
        p = a[7:0] * 8'd29;
        return p ^ {a[11:8], a[11:8]};
    endfunction

    initial begin
        seed      = 1581;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int l = 0; l < 256; l++) begin
            for (int b = 0; b < `DC_LINE_BYTES; b++) begin
                lines[l][8*b +: 8] = preset_byte({l[7:0], b[3:0]});
            end
        end
    end

    assign line_idx = mem_addr[11:4];  // addresses wrap at 4 KB

    always @(posedge clk) begin
        if (reset) begin
            mem_ack  <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 0;
        end else if (mem_req && !busy && !mem_ack) begin
            busy     <= 1'b1;
            wait_cnt <= 1 + {$random(seed)} % 5;  // 1 to 5 cycles
        end else if (busy && !mem_ack) begin
            if (wait_cnt > 1) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                mem_ack <= 1'b1;
                if (mem_we) begin
                    lines[line_idx] <= mem_wdata;
                end else begin
                    mem_rdata <= lines[line_idx];
                end
            end
        end else if (mem_ack && !mem_req) begin
            mem_ack <= 1'b0;  // closes the handshake
            busy    <= 1'b0;
        end
    end

endmodule

/* test/tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module tb_dcache;

    localparam int num_requests = 100;
    localparam int txn_worst    = 16;  // start pulse to done with the slowest memory
    localparam int cycle_limit  = num_requests * (2 + 2 * txn_worst) + 500;

    logic                     clk;
    logic                     reset;
    logic                     valid, op, signed_ext;
    logic [31:0]              addr, wdata;
    dcache_pkg::access_size_t size;
    logic                     data_valid, exception;
    logic [31:0]              rdata;
    logic                     mem_req, mem_we, mem_ack;
    logic [31:0]              mem_addr;
    logic [`DC_LINE_W-1:0]    mem_wdata, mem_rdata;

    logic [7:0]  shadow [4096];
    integer      seed;
    int          errors = 0;
    int          errors_before = 0;
    int          checks = 0;
    int          tests = 0;
    int          mem_writes = 0;
    int          mem_txns = 0;
    int          cycle_count = 0;
    logic [31:0] last_rdata;
    logic        last_exc;
    int          last_cycles;
    logic        mem_seen = 1'b0;
    logic        req_prev = 1'b0;
    logic        ack_prev = 1'b0;
    logic [31:0] addr_prev;

    dcache_top dut_i (
        .clk, .reset, .valid, .op, .signed_ext, .addr, .wdata, .size,
        .data_valid, .exception, .rdata,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

    dcache_mem_model mem_i (
        .clk, .reset, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [7:0] preset_byte(input logic [11:0] a);
        logic [7:0] p;
        p = a[7:0] * 8'd29;
        return p ^ {a[11:8], a[11:8]};
    endfunction

    // little endian view of the shadow memory
    function automatic logic [31:0] expected_load(input logic [11:0] a,
                                                  input dcache_pkg::access_size_t sz,
                                                  input logic sx);
        logic [31:0] v;
        case (sz)
            dcache_pkg::size_byte: v = {{24{sx & shadow[a][7]}}, shadow[a]};
            dcache_pkg::size_half: v = {{16{sx & shadow[a+1][7]}}, shadow[a+1], shadow[a]};
            default:               v = {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
        endcase
        return v;
    endfunction

    task automatic store_shadow(input logic [11:0] a, input dcache_pkg::access_size_t sz,
                                input logic [31:0] d);
        int n;
        n = (sz == dcache_pkg::size_byte) ? 1 : (sz == dcache_pkg::size_half) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            shadow[a + k] = d[8*k +: 8];
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s returned %08h, expected %08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    // one request and the wait for data_valid
    task automatic run_access(input logic is_store, input dcache_pkg::access_size_t sz,
                              input logic sx, input logic [31:0] a, input logic [31:0] d);
        @(posedge clk);
        #1;
        valid      = 1'b1;
        op         = is_store;
        size       = sz;
        signed_ext = sx;
        addr       = a;
        wdata      = d;
        mem_seen   = 1'b0;
        @(posedge clk);
        #1;
        valid       = 1'b0;
        last_cycles = 0;
        do begin
            @(negedge clk);
            last_cycles++;
        end while (!data_valid);
        last_rdata = rdata;
        last_exc   = exception;
    endtask

    task automatic load_check(input logic [31:0] a, input dcache_pkg::access_size_t sz,
                              input logic sx);
        logic [31:0] exp;
        exp = expected_load(a[11:0], sz, sx);
        run_access(1'b0, sz, sx, a, 32'h0);
        check_true(!last_exc, "aligned load raised an exception");
        check_value($sformatf("load at %08h", a), last_rdata, exp);
    endtask

    task automatic store_check(input logic [31:0] a, input dcache_pkg::access_size_t sz,
                               input logic [31:0] d);
        run_access(1'b1, sz, 1'b0, a, d);
        check_true(!last_exc, "aligned store raised an exception");
        store_shadow(a[11:0], sz, d);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    // memory port protocol sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (mem_req) begin
                mem_seen = 1'b1;
            end
            if (mem_req && !req_prev) begin
                mem_txns++;
                checks++;
                assert (!ack_prev) else begin
                    $display("error at %0t ns: mem_req rose while mem_ack was high", $time);
                    errors++;
                end
                if (mem_we) begin
                    mem_writes++;
                    check_value("writeback address low bits", {28'h0, mem_addr[3:0]}, 32'h0);
                end
            end
            if (mem_req && req_prev) begin
                check_value("mem_addr during mem_req", mem_addr, addr_prev);
            end
        end
        req_prev  = mem_req;
        ack_prev  = mem_ack;
        addr_prev = mem_addr;
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] a;
        int          writes_before;
        int          txns_before;
        seed       = 1581;
        reset      = 1'b1;
        valid      = 1'b0;
        op         = 1'b0;
        signed_ext = 1'b0;
        addr       = '0;
        wdata      = '0;
        size       = dcache_pkg::size_word;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = preset_byte(i[11:0]);
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        load_check(32'h100, dcache_pkg::size_word, 1'b0);
        check_true(mem_seen, "first load after reset did not refill from memory");
        load_check(32'h104, dcache_pkg::size_word, 1'b0);
        check_true(last_cycles == 2, "second load of a cached line was not a 2-cycle hit");
        check_true(!mem_seen, "hit load raised mem_req");
        end_test("load after reset");

        for (int o = 0; o < 16; o++) begin
            load_check(32'h210 + o, dcache_pkg::size_byte, 1'b0);
            load_check(32'h210 + o, dcache_pkg::size_byte, 1'b1);
        end
        for (int o = 0; o < 16; o += 2) begin
            load_check(32'h210 + o, dcache_pkg::size_half, 1'b0);
            load_check(32'h210 + o, dcache_pkg::size_half, 1'b1);
        end
        end_test("narrow loads");

        // hits on the line cached above, then misses in sets 2 to 4
        store_check(32'h213, dcache_pkg::size_byte, 32'h1234_56a7);
        load_check(32'h210, dcache_pkg::size_word, 1'b0);
        store_check(32'h216, dcache_pkg::size_half, 32'hffff_81c4);
        load_check(32'h214, dcache_pkg::size_word, 1'b0);
        store_check(32'h218, dcache_pkg::size_word, 32'hdead_5eed);
        load_check(32'h218, dcache_pkg::size_word, 1'b0);
        store_check(32'h321, dcache_pkg::size_byte, 32'h0bad_c05a);
        check_true(mem_seen, "store to an uncached line did not refill");
        load_check(32'h320, dcache_pkg::size_word, 1'b0);
        store_check(32'h43a, dcache_pkg::size_half, 32'h7777_9c3e);
        load_check(32'h438, dcache_pkg::size_word, 1'b0);
        store_check(32'h544, dcache_pkg::size_word, 32'h1234_f00d);
        load_check(32'h544, dcache_pkg::size_word, 1'b0);
        end_test("store merge");

        writes_before = mem_writes;
        for (int t = 0; t < 5; t++) begin
            store_check(32'h050 + 32'h100 * t, dcache_pkg::size_word, $random(seed));
        end
        // whole evicted line comes back from memory
        for (int w = 0; w < 4; w++) begin
            load_check(32'h050 + 4 * w, dcache_pkg::size_word, 1'b0);
        end
        load_check(32'h150, dcache_pkg::size_word, 1'b0);
        check_true(mem_writes > writes_before, "no writeback seen while evicting dirty lines");
        end_test("eviction");

        run_access(1'b1, dcache_pkg::size_half, 1'b0, 32'h211, 32'hffff_ffff);
        check_true(last_exc, "misaligned halfword store raised no exception");
        check_true(last_cycles == 2, "misaligned access did not answer after 2 cycles");
        run_access(1'b1, dcache_pkg::size_word, 1'b0, 32'h212, 32'hffff_ffff);
        check_true(last_exc, "misaligned word store raised no exception");
        run_access(1'b0, dcache_pkg::size_word, 1'b0, 32'h215, 32'h0);
        check_true(last_exc, "misaligned word load raised no exception");
        load_check(32'h210, dcache_pkg::size_word, 1'b0);
        load_check(32'h214, dcache_pkg::size_word, 1'b0);
        end_test("misaligned");

        txns_before = mem_txns;
        for (int r = 0; r < 20; r++) begin
            rnd = $random(seed);
            a   = {20'h0, rnd[11:2], 2'b00};
            if (rnd[12]) begin
                store_check(a, dcache_pkg::size_word, $random(seed));
            end else begin
                load_check(a, dcache_pkg::size_word, rnd[13]);
            end
        end
        check_true(mem_txns > txns_before, "random accesses caused no memory transaction");
        end_test("random mix and protocol");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
